// ==== microExec.f ====
source/microwordPkg.sv
source/datapathPkg.sv
source/microwordReceiver.sv
source/microwordFifo.sv
source/controlDecoder.sv
source/executionDatapath.sv
source/microExecTop.sv
tb/microExecTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the microExec simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f microExec.f \
    --top-module microExecTb -Mdir obj_dir -o microExecSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/microExecSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
exit 0

// ==== tb/microExecTb.sv ====
// Microword execution testbench
`timescale 1ns/10ps
`default_nettype none

module microExecTb;

    localparam int ackTimeout   = 50;   // cycles per handshake edge
    localparam int drainTimeout = 200;  // cycles for outstanding words

    logic        clk;
    logic        reset;
    logic [15:0] wordIn;
    logic        wordReq;
    logic        wordAck;
    logic [15:0] ioIn;
    logic        stepValid;
    logic [15:0] busValue;
    logic [15:0] pcValue;
    logic        jumpTaken;
    logic [15:0] outValue;

    logic [31:0] lcgState = 32'hc407493f;
    logic [15:0] wordQ [$];  // sent words, oldest first
    logic [15:0] ioQ [$];    // ioIn that goes with each sent word
    int          ackCount = 0;
    int          stepCount = 0;
    int          errorCount = 0;
    logic        ackPrev = 1'b0;

    // shadow state of the datapath
    logic [15:0] mPc, mX, mY, mMar, mOut;
    logic [15:0] mRam [16];
    logic        mCarry, mZero, mGt, mLt;

    logic [15:0] chkWord, chkIo, expBus;
    logic        expJump;

    microExecTop #(.fifoDepth(4)) microExecTop_i (
        .clk(clk), .reset(reset), .wordIn(wordIn), .wordReq(wordReq), .wordAck(wordAck),
        .ioIn(ioIn), .stepValid(stepValid), .busValue(busValue), .pcValue(pcValue),
        .jumpTaken(jumpTaken), .outValue(outValue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [15:0] busWord(input logic [2:0] src, input logic rt,
            input logic pp, input logic [2:0] dst, input logic [3:0] mask);
        return {1'b0, src, rt, pp, 1'b0, dst, mask, 2'b00};
    endfunction

    function automatic logic [15:0] aluWord(input logic [5:0] ctrl, input logic [2:0] dst,
            input logic [3:0] mask);
        return {1'b1, ctrl, dst, mask, 2'b00};
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model, one microword per call

    function automatic void stepModel(input logic [15:0] w, input logic [15:0] io,
            output logic [15:0] bus, output logic jump);
        logic [15:0] x;
        logic [15:0] y;
        logic [16:0] sum;
        if (w[15]) begin
            x = w[14] ? mX : 16'h0000;
            if (w[13]) x = ~x;
            y = w[12] ? mY : 16'h0000;
            if (w[11]) y = ~y;
            sum = {1'b0, x} + {1'b0, y};
            bus = w[10] ? sum[15:0] : (x & y);
            if (w[9]) bus = ~bus;
            mCarry = w[10] && !w[9] && sum[16];
            mZero  = (bus == 16'h0000);
            mLt    = bus[15];
            mGt    = !bus[15] && (bus != 16'h0000);
        end else begin
            case (w[14:12])
                microwordPkg::SRC_PC:  bus = mPc;
                microwordPkg::SRC_IOL: bus = {8'h00, io[7:0]};
                microwordPkg::SRC_IOH: bus = {8'h00, io[15:8]};
                microwordPkg::SRC_RAM: bus = mRam[mMar[3:0]];
                microwordPkg::SRC_X:   bus = mX;
                microwordPkg::SRC_Y:   bus = mY;
                default:               bus = 16'h0000;  // reserved sources
            endcase
            if (w[10]) mPc = mPc + 16'd1;
            else if (w[11]) mPc = mY;  // old Y, before the write below
        end
        case (w[8:6])
            microwordPkg::DST_MAR: mMar = bus;
            microwordPkg::DST_RAM: mRam[mMar[3:0]] = bus;
            microwordPkg::DST_X:   mX = bus;
            microwordPkg::DST_Y:   mY = bus;
            microwordPkg::DST_OUT: mOut = bus;
            default: ;  // IR has no visible output
        endcase
        jump = (w[5] && mCarry) || (w[4] && mZero) || (w[3] && mGt) || (w[2] && mLt);
    endfunction

    task automatic abortRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareValue(input string name, input logic [15:0] got,
            input logic [15:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abortRun("value mismatch");
        end
    endtask

    // compare every executed word against the model
    always @(negedge clk) begin
        if (!reset && stepValid) begin
            if (wordQ.size() == 0) begin
                abortRun("stepValid pulsed with no word outstanding");
            end else begin
                chkWord = wordQ.pop_front();
                chkIo   = ioQ.pop_front();
                stepModel(chkWord, chkIo, expBus, expJump);
                compareValue("busValue", busValue, expBus);
                compareValue("pcValue", pcValue, mPc);
                compareValue("jumpTaken", {15'h0000, jumpTaken}, {15'h0000, expJump});
                compareValue("outValue", outValue, mOut);
                stepCount++;
            end
        end
    end

    // count acknowledged words straight from wordAck
    always @(negedge clk) begin
        if (reset) begin
            ackPrev = 1'b0;
        end else begin
            if (wordAck && !ackPrev) begin
                ackCount++;
            end
            ackPrev = wordAck;
        end
    end

    ////////////////////////////////////////////////////////////
    // four-phase driver, called and returning at a falling edge

    task automatic waitAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (wordAck !== level && cycles < ackTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (wordAck !== level) abortRun({"timed out waiting for wordAck to ", what});
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        while (wordQ.size() != 0 && cycles < drainTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (wordQ.size() != 0) abortRun("timed out waiting for stepValid on sent words");
    endtask

    task automatic sendWord(input logic [15:0] w, input logic [15:0] io);
        if (io !== ioIn) begin
            waitDrained();  // ioIn only moves once nothing is in flight
            ioIn = io;
        end
        wordQ.push_back(w);
        ioQ.push_back(io);
        wordIn  = w;
        wordReq = 1'b1;
        waitAck(1'b1, "rise");
        wordReq = 1'b0;
        waitAck(1'b0, "fall");
    endtask

    task automatic loadOperands();
        logic [31:0] r;
        r = nextRand();
        sendWord(busWord(r[12] ? microwordPkg::SRC_IOH : microwordPkg::SRC_IOL, 1'b0, 1'b0,
                         microwordPkg::DST_X, 4'h0), r[31:16]);
        sendWord(busWord(r[13] ? microwordPkg::SRC_IOH : microwordPkg::SRC_IOL, 1'b0, 1'b0,
                         microwordPkg::DST_Y, 4'h0), r[31:16]);
        if (r[14]) sendWord(aluWord(6'b110100, microwordPkg::DST_X, 4'h0), ioIn);  // X = ~X
        if (r[15]) sendWord(aluWord(6'b011100, microwordPkg::DST_Y, 4'h0), ioIn);  // Y = ~Y
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] ioRand;
        logic [3:0]  mask;
        reset   = 1'b1;
        wordIn  = 16'h0000;
        wordReq = 1'b0;
        ioIn    = 16'h0000;
        {mPc, mX, mY, mMar, mOut} = '0;
        {mCarry, mZero, mGt, mLt} = '0;
        for (int i = 0; i < 16; i++) mRam[i] = 16'h0000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // bus sources and reserved codes
        r = nextRand();
        sendWord(busWord(microwordPkg::SRC_IOL, 1'b0, 1'b0, microwordPkg::DST_X, 4'h0), r[15:0]);
        sendWord(busWord(microwordPkg::SRC_IOH, 1'b0, 1'b0, microwordPkg::DST_Y, 4'h0), r[15:0]);
        sendWord(busWord(microwordPkg::SRC_X, 1'b0, 1'b0, microwordPkg::DST_NONE, 4'h0), ioIn);
        sendWord(busWord(microwordPkg::SRC_Y, 1'b0, 1'b0, microwordPkg::DST_NONE, 4'h0), ioIn);
        sendWord(busWord(3'b110, 1'b0, 1'b0, microwordPkg::DST_IR, 4'h0), ioIn);
        sendWord(busWord(3'b111, 1'b0, 1'b0, microwordPkg::DST_NONE, 4'h0), ioIn);

        // all ALU controls, one jump mask bit at a time
        for (int c = 0; c < 64; c++) begin
            loadOperands();
            mask = (c % 8 == 7) ? 4'hf : (4'h1 << (c % 4));
            sendWord(aluWord(6'(c), microwordPkg::DST_NONE, mask), ioIn);
        end

        // PC control
        r = nextRand();
        sendWord(busWord(microwordPkg::SRC_IOL, 1'b0, 1'b0, microwordPkg::DST_Y, 4'h0), r[15:0]);
        sendWord(busWord(microwordPkg::SRC_PC, 1'b0, 1'b1, microwordPkg::DST_NONE, 4'h0), ioIn);
        sendWord(busWord(microwordPkg::SRC_PC, 1'b1, 1'b0, microwordPkg::DST_NONE, 4'h0), ioIn);
        sendWord(busWord(microwordPkg::SRC_PC, 1'b1, 1'b1, microwordPkg::DST_NONE, 4'h0), ioIn);
        sendWord(busWord(microwordPkg::SRC_PC, 1'b0, 1'b0, microwordPkg::DST_NONE, 4'h0), ioIn);

        // memory and output register
        for (int i = 0; i < 6; i++) begin
            r = nextRand();
            sendWord(busWord(microwordPkg::SRC_IOL, 1'b0, 1'b0, microwordPkg::DST_MAR, 4'h0),
                     r[15:0]);
            sendWord(busWord(microwordPkg::SRC_IOH, 1'b0, 1'b0, microwordPkg::DST_X, 4'h0), ioIn);
            sendWord(busWord(microwordPkg::SRC_X, 1'b0, 1'b0, microwordPkg::DST_RAM, 4'h0), ioIn);
            sendWord(busWord(microwordPkg::SRC_RAM, 1'b0, 1'b0, microwordPkg::DST_OUT, 4'h0),
                     ioIn);
        end

        // burst with ioIn held, no drain between words
        for (int i = 0; i < 40; i++) begin
            r = nextRand();
            sendWord(r[31:16], ioIn);
        end

        // random mix, new ioIn every tenth word
        for (int i = 0; i < 300; i++) begin
            r = nextRand();
            if (i % 10 == 0) begin
                ioRand = nextRand();
                sendWord(r[31:16], ioRand[31:16]);
            end else begin
                sendWord(r[31:16], ioIn);
            end
        end

        waitDrained();
        compareValue("stepValid count", 16'(stepCount), 16'(ackCount));
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/microExecTop.sv ====
// Microword execution top level
`timescale 1ns/10ps
`default_nettype none

module microExecTop #(
    parameter int fifoDepth = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [microwordPkg::WORD_WIDTH-1:0]  wordIn,
    input  logic                                 wordReq,
    output logic                                 wordAck,
    input  logic [datapathPkg::DATA_WIDTH-1:0]   ioIn,
    output logic                                 stepValid,
    output logic [datapathPkg::DATA_WIDTH-1:0]   busValue,
    output logic [datapathPkg::DATA_WIDTH-1:0]   pcValue,
    output logic                                 jumpTaken,
    output logic [datapathPkg::DATA_WIDTH-1:0]   outValue
);

    logic                     push;
    logic                     full;
    logic                     pop;
    logic                     empty;
    microwordPkg::microword_t pushWord;
    microwordPkg::microword_t popWord;

    ////////////////////////////////////////////////////////////
    // producer, buffer, consumer

    microwordReceiver receiver_i (
        .clk      (clk),
        .reset    (reset),
        .wordIn   (wordIn),
        .wordReq  (wordReq),
        .wordAck  (wordAck),
        .full     (full),
        .push     (push),
        .pushWord (pushWord)
    );

    microwordFifo #(
        .fifoDepth (fifoDepth)
    ) fifo_i (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .pushWord (pushWord),
        .full     (full),
        .pop      (pop),
        .popWord  (popWord),
        .empty    (empty)
    );

    executionDatapath datapath_i (
        .clk       (clk),
        .reset     (reset),
        .empty     (empty),
        .pop       (pop),
        .popWord   (popWord),
        .ioIn      (ioIn),
        .stepValid (stepValid),
        .busValue  (busValue),
        .pcValue   (pcValue),
        .jumpTaken (jumpTaken),
        .outValue  (outValue)
    );

endmodule

`default_nettype wire

// ==== source/executionDatapath.sv ====
// Execution datapath
`timescale 1ns/10ps
`default_nettype none

module executionDatapath (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                empty,
    output logic                                pop,
    input  microwordPkg::microword_t            popWord,
    input  logic [datapathPkg::DATA_WIDTH-1:0]  ioIn,
    output logic                                stepValid,
    output logic [datapathPkg::DATA_WIDTH-1:0]  busValue,
    output logic [datapathPkg::DATA_WIDTH-1:0]  pcValue,
    output logic                                jumpTaken,
    output logic [datapathPkg::DATA_WIDTH-1:0]  outValue
);

    localparam int dataWidth = datapathPkg::DATA_WIDTH;
    localparam int halfWidth = dataWidth / 2;
    localparam int ramWords  = 2 ** datapathPkg::RAM_ADDR_WIDTH;

    logic                                    aluMode;
    logic [microwordPkg::ALU_CTRL_WIDTH-1:0] aluCtrl;
    logic [microwordPkg::SRC_WIDTH-1:0]      srcSel;
    logic [microwordPkg::DST_WIDTH-1:0]      dstSel;
    logic                                    pcInc;
    logic                                    pcLoad;
    logic [microwordPkg::JUMP_WIDTH-1:0]     jumpMask;

    logic [dataWidth-1:0] pcReg, xReg, yReg, marReg, outReg;
    logic [dataWidth-1:0] ram [ramWords];
    logic [datapathPkg::FLAG_COUNT-1:0] flags, aluFlags, flagsNext;
    logic [datapathPkg::RAM_ADDR_WIDTH-1:0] ramAddr;
    logic [dataWidth-1:0] aluX, aluY, aluRaw, aluResult, busNow;
    logic [dataWidth:0]   aluSum;
    logic                 jumpNow;

    controlDecoder decoder_i (
        .word     (popWord),
        .aluMode  (aluMode),
        .aluCtrl  (aluCtrl),
        .srcSel   (srcSel),
        .dstSel   (dstSel),
        .pcInc    (pcInc),
        .pcLoad   (pcLoad),
        .jumpMask (jumpMask)
    );

    assign pop      = !empty;  // one word per cycle
    assign ramAddr  = marReg[datapathPkg::RAM_ADDR_WIDTH-1:0];
    assign pcValue  = pcReg;
    assign outValue = outReg;

    ////////////////////////////////////////////////////////////
    // ALU and flags

    always_comb begin
        aluX = aluCtrl[microwordPkg::ALU_EX] ? xReg : '0;
        if (aluCtrl[microwordPkg::ALU_NX]) begin
            aluX = ~aluX;
        end
        aluY = aluCtrl[microwordPkg::ALU_EY] ? yReg : '0;
        if (aluCtrl[microwordPkg::ALU_NY]) begin
            aluY = ~aluY;
        end
        aluSum    = {1'b0, aluX} + {1'b0, aluY};
        aluRaw    = aluCtrl[microwordPkg::ALU_F] ? aluSum[dataWidth-1:0] : (aluX & aluY);
        aluResult = aluCtrl[microwordPkg::ALU_NO] ? ~aluRaw : aluRaw;

        aluFlags[datapathPkg::FLAG_CARRY] = aluCtrl[microwordPkg::ALU_F] &&
                                            !aluCtrl[microwordPkg::ALU_NO] && aluSum[dataWidth];
        aluFlags[datapathPkg::FLAG_ZERO]  = (aluResult == '0);
        aluFlags[datapathPkg::FLAG_LT]    = aluResult[dataWidth-1];
        aluFlags[datapathPkg::FLAG_GT]    = !aluResult[dataWidth-1] && (aluResult != '0);
        flagsNext = aluMode ? aluFlags : flags;

        jumpNow = (jumpMask[microwordPkg::JMP_C]  && flagsNext[datapathPkg::FLAG_CARRY]) ||
                  (jumpMask[microwordPkg::JMP_Z]  && flagsNext[datapathPkg::FLAG_ZERO])  ||
                  (jumpMask[microwordPkg::JMP_GT] && flagsNext[datapathPkg::FLAG_GT])    ||
                  (jumpMask[microwordPkg::JMP_LT] && flagsNext[datapathPkg::FLAG_LT]);
    end

    ////////////////////////////////////////////////////////////
    // bus source

    always_comb begin
        busNow = '0;  // reserved codes
        if (aluMode) begin
            busNow = aluResult;
        end else begin
            case (srcSel)
                microwordPkg::SRC_PC:  busNow = pcReg;
                microwordPkg::SRC_IOL: busNow = {{(dataWidth - halfWidth){1'b0}},
                                                 ioIn[halfWidth-1:0]};
                microwordPkg::SRC_IOH: busNow = {{halfWidth{1'b0}}, ioIn[dataWidth-1:halfWidth]};
                microwordPkg::SRC_RAM: busNow = ram[ramAddr];
                microwordPkg::SRC_X:   busNow = xReg;
                microwordPkg::SRC_Y:   busNow = yReg;
                default:               busNow = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // state update at the pop edge

    always_ff @(posedge clk) begin
        if (reset) begin
            pcReg     <= '0;
            xReg      <= '0;
            yReg      <= '0;
            marReg    <= '0;
            outReg    <= '0;
            flags     <= '0;
            stepValid <= 1'b0;
            jumpTaken <= 1'b0;
            for (int i = 0; i < ramWords; i++) begin
                ram[i] <= '0;
            end
        end else begin
            stepValid <= pop;
            if (pop) begin
                jumpTaken <= jumpNow;
                flags     <= flagsNext;
                if (pcInc) begin
                    pcReg <= pcReg + 1'b1;
                end else if (pcLoad) begin
                    pcReg <= yReg;  // Y before this word's write
                end
                case (dstSel)
                    microwordPkg::DST_NONE: ;
                    microwordPkg::DST_MAR:  marReg <= busNow;
                    microwordPkg::DST_IR:   ;  // nothing downstream reads the IR
                    microwordPkg::DST_RAM:  ram[ramAddr] <= busNow;
                    microwordPkg::DST_X:    xReg <= busNow;
                    microwordPkg::DST_Y:    yReg <= busNow;
                    microwordPkg::DST_OUT:  outReg <= busNow;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            busValue <= busNow;  // trace for the stepValid cycle
        end
    end

endmodule

`default_nettype wire

// ==== source/controlDecoder.sv ====
// Microword control decoder
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
    input  microwordPkg::microword_t                   word,
    output logic                                       aluMode,
    output logic [microwordPkg::ALU_CTRL_WIDTH-1:0]    aluCtrl,
    output logic [microwordPkg::SRC_WIDTH-1:0]         srcSel,
    output logic [microwordPkg::DST_WIDTH-1:0]         dstSel,
    output logic                                       pcInc,
    output logic                                       pcLoad,
    output logic [microwordPkg::JUMP_WIDTH-1:0]        jumpMask
);

    ////////////////////////////////////////////////////////////
    // fields common to both views

    always_comb begin
        aluMode  = word.alu.eo;
        dstSel   = word.alu.dst;
        jumpMask = word.alu.jumpMask;
    end

    ////////////////////////////////////////////////////////////
    // ALU view, eo high

    always_comb begin
        aluCtrl = '0;
        aluCtrl[microwordPkg::ALU_EX] = word.alu.ex;
        aluCtrl[microwordPkg::ALU_NX] = word.alu.nx;
        aluCtrl[microwordPkg::ALU_EY] = word.alu.ey;
        aluCtrl[microwordPkg::ALU_NY] = word.alu.ny;
        aluCtrl[microwordPkg::ALU_F]  = word.alu.f;
        aluCtrl[microwordPkg::ALU_NO] = word.alu.no;
    end

    ////////////////////////////////////////////////////////////
    // bus view, eo low

    always_comb begin
        srcSel = '0;  // ALU drives the bus
        pcInc  = 1'b0;
        pcLoad = 1'b0;
        if (!word.bus.eo) begin
            srcSel = word.bus.src;
            pcInc  = word.bus.pp;
            pcLoad = word.bus.rt && !word.bus.pp;  // pp wins over rt
        end
    end

endmodule

`default_nettype wire

// ==== source/microwordFifo.sv ====
// Microword FIFO
`timescale 1ns/10ps
`default_nettype none

module microwordFifo #(
    parameter int fifoDepth = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  microwordPkg::microword_t pushWord,
    output logic                     full,
    input  logic                     pop,
    output microwordPkg::microword_t popWord,
    output logic                     empty
);

    localparam int addrWidth = $clog2(fifoDepth);

    microwordPkg::microword_t mem [fifoDepth];

    logic [addrWidth:0] wrPtr;  // extra bit tells full from empty
    logic [addrWidth:0] rdPtr;
    logic               doPush;
    logic               doPop;

    generate
        if (fifoDepth < 2 || (fifoDepth & (fifoDepth - 1)) != 0) begin : gDepthCheck
            $error("fifoDepth must be a power of two and at least 2");
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // status

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[addrWidth] != rdPtr[addrWidth]) &&
                   (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);

    assign doPush = push && (!full || pop);  // a pop frees the slot when full
    assign doPop  = pop && !empty;

    assign popWord = mem[rdPtr[addrWidth-1:0]];  // head, valid while empty low

    ////////////////////////////////////////////////////////////
    // storage and pointers

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr[addrWidth-1:0]] <= pushWord;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
        push && full |-> pop);

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== source/microwordReceiver.sv ====
// Four-phase microword receiver
`timescale 1ns/10ps
`default_nettype none

module microwordReceiver (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [microwordPkg::WORD_WIDTH-1:0]   wordIn,
    input  logic                                  wordReq,
    output logic                                  wordAck,
    input  logic                                  full,
    output logic                                  push,
    output microwordPkg::microword_t              pushWord
);

    localparam logic stateIdle  = 1'b0;  // waiting for wordReq high
    localparam logic stateAcked = 1'b1;  // waiting for wordReq low

    logic state;

    assign wordAck = (state == stateAcked);

    ////////////////////////////////////////////////////////////
    // handshake FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                stateIdle: begin
                    if (wordReq && !full) begin  // hold off while full
                        state <= stateAcked;
                        push  <= 1'b1;
                    end
                end
                stateAcked: begin
                    if (!wordReq) begin
                        state <= stateIdle;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stateIdle && wordReq) begin
            pushWord <= microwordPkg::microword_t'(wordIn);  // stable while req high
        end
    end

    // the full seen at accept time still holds when the push lands
    pushNotFull: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

endmodule

`default_nettype wire

// ==== source/datapathPkg.sv ====
// Datapath definitions
`default_nettype none

package datapathPkg;

    ////////////////////////////////////////////////////////////
    // widths

    localparam int DATA_WIDTH     = 16;
    localparam int RAM_ADDR_WIDTH = 4;  // 16-word scratch RAM

    ////////////////////////////////////////////////////////////
    // flags register layout

    localparam int FLAG_COUNT = 4;

    localparam int FLAG_CARRY = 0;  // carry out of the add
    localparam int FLAG_ZERO  = 1;
    localparam int FLAG_GT    = 2;  // signed, above zero
    localparam int FLAG_LT    = 3;  // signed, below zero

endpackage

`default_nettype wire

// ==== source/microwordPkg.sv ====
// Microword format definitions
`default_nettype none

package microwordPkg;

    localparam int WORD_WIDTH = 16;

    ////////////////////////////////////////////////////////////
    // field widths and bit positions

    localparam int SRC_WIDTH      = 3;
    localparam int DST_WIDTH      = 3;
    localparam int ALU_CTRL_WIDTH = 6;
    localparam int JUMP_WIDTH     = 4;

    localparam int ALU_EX = 5;  // aluCtrl bits, ex down to no
    localparam int ALU_NX = 4;
    localparam int ALU_EY = 3;
    localparam int ALU_NY = 2;
    localparam int ALU_F  = 1;
    localparam int ALU_NO = 0;

    localparam int JMP_C  = 3;  // jumpMask bits, jc down to jlt
    localparam int JMP_Z  = 2;
    localparam int JMP_GT = 1;
    localparam int JMP_LT = 0;

    ////////////////////////////////////////////////////////////
    // bus sources, 110 and 111 reserved

    localparam logic [SRC_WIDTH-1:0] SRC_PC  = 3'b000;
    localparam logic [SRC_WIDTH-1:0] SRC_IOH = 3'b001;
    localparam logic [SRC_WIDTH-1:0] SRC_IOL = 3'b010;
    localparam logic [SRC_WIDTH-1:0] SRC_RAM = 3'b011;
    localparam logic [SRC_WIDTH-1:0] SRC_X   = 3'b100;
    localparam logic [SRC_WIDTH-1:0] SRC_Y   = 3'b101;

    localparam logic [DST_WIDTH-1:0] DST_NONE = 3'b000;
    localparam logic [DST_WIDTH-1:0] DST_MAR  = 3'b001;
    localparam logic [DST_WIDTH-1:0] DST_IR   = 3'b010;
    localparam logic [DST_WIDTH-1:0] DST_RAM  = 3'b011;
    localparam logic [DST_WIDTH-1:0] DST_X    = 3'b100;
    localparam logic [DST_WIDTH-1:0] DST_Y    = 3'b101;
    localparam logic [DST_WIDTH-1:0] DST_OUT  = 3'b110;

    typedef struct packed {
        logic                  eo;  // 1 in this view
        logic                  ex;
        logic                  nx;
        logic                  ey;
        logic                  ny;
        logic                  f;
        logic                  no;
        logic [DST_WIDTH-1:0]  dst;
        logic [JUMP_WIDTH-1:0] jumpMask;
        logic [1:0]            unused;
    } aluView_t;

    typedef struct packed {
        logic                  eo;  // 0 in this view
        logic [SRC_WIDTH-1:0]  src;
        logic                  rt;
        logic                  pp;
        logic                  spare;
        logic [DST_WIDTH-1:0]  dst;
        logic [JUMP_WIDTH-1:0] jumpMask;
        logic [1:0]            unused;
    } busView_t;

    typedef union packed {
        aluView_t alu;
        busView_t bus;
    } microword_t;

endpackage

`default_nettype wire
